// File: dv/icache_chk.sv
`timescale 1ns/1ns

module icache_chk (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req_valid,
    input  logic                  cpu_req_ready,
    input  icache_pkg::addr_t     mem_req_addr,
    input  logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    input  logic                  fill_en,
    input  logic                  cache_enable
);

    int assert_failures = 0;

    // memory request holds until the memory answers
    mem_req_held: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req_addr))
    )
    else
    begin
        assert_failures++;
        $error("memory request dropped or changed before mem_req_ready");
    end

    cpu_ready_with_valid: assert property (
        @(posedge clk) disable iff (rst)
        cpu_req_ready |-> cpu_req_valid
    )
    else
    begin
        assert_failures++;
        $error("cpu_req_ready without a pending fetch");
    end

    // no line fill while the cache is off
    fill_only_enabled: assert property (
        @(posedge clk) disable iff (rst)
        fill_en |-> cache_enable
    )
    else
    begin
        assert_failures++;
        $error("line fill while the cache is disabled");
    end

endmodule

bind icache_core icache_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req_ready (cpu_req_ready),
    .mem_req_addr  (mem_req_addr),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .fill_en       (fill_en),
    .cache_enable  (cache_enable)
);

// File: dv/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 4;
    localparam int MAX_ENTRIES      = 64;
    localparam int MEM_WORDS        = 16384;
    localparam int CYCLES_PER_ENTRY = 20;

    // table entry kinds
    localparam int K_WRITE = 0;
    localparam int K_READ  = 1;
    localparam int K_FETCH = 2;

    logic                clk;
    logic                rst;
    icache_pkg::addr_t   cpu_req_addr;
    logic                cpu_req_valid;
    icache_pkg::word_t   cpu_req_data;
    logic                cpu_req_ready;
    icache_pkg::addr_t   mem_req_addr;
    logic                mem_req_valid;
    icache_pkg::word_t   mem_rdata = '0;
    logic                mem_req_ready = 1'b0;
    logic                psel;
    logic                penable;
    logic                pwrite;
    icache_pkg::paddr_t  paddr;
    icache_pkg::word_t   pwdata;
    icache_pkg::word_t   prdata;
    logic                pready;
    logic                pslverr;

    icache_pkg::word_t   mem_words [MEM_WORDS];
    int                  seed;
    int                  mem_reqs = 0;
    int                  mem_wait = 0;
    logic                mem_busy = 1'b0;

    // aux holds the memory request count of a fetch or the pslverr of an apb access
    int                  t_kind [MAX_ENTRIES];
    icache_pkg::addr_t   t_addr [MAX_ENTRIES];
    icache_pkg::word_t   t_data [MAX_ENTRIES];
    int                  t_aux  [MAX_ENTRIES];
    int                  n_entries;

    int                  pass_count = 0;
    int                  fail_count = 0;
    int                  entry_errors;
    int                  cycles = 0;
    int                  cycle_limit = 1000;

    icache_top u_icache_top (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_rdata     (mem_rdata),
        .mem_req_ready (mem_req_ready),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    // memory model answering after 0 to 5 wait cycles
    always @(posedge clk)
    begin
        #1;
        if (rst)
        begin
            mem_req_ready = 1'b0;
            mem_busy      = 1'b0;
        end
        else if (mem_req_ready)
        begin
            // read completed on this edge
            mem_req_ready = 1'b0;
            mem_busy      = 1'b0;
        end
        else if (mem_req_valid)
        begin
            if (!mem_busy)
            begin
                mem_busy = 1'b1;
                mem_wait = int'({$random(seed)} % 6);
            end
            if (mem_wait == 0)
            begin
                mem_req_ready = 1'b1;
                mem_rdata     = mem_words[mem_req_addr[icache_pkg::ADDR_W-1:2]];
                mem_reqs++;
            end
            else
            begin
                mem_wait--;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input icache_pkg::word_t got,
                              input icache_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            entry_errors++;
        end
    endtask

    task automatic check_count(input string name, input icache_pkg::count_t got,
                               input icache_pkg::count_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            entry_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            entry_errors++;
        end
    endtask

    task automatic add_entry(input int kind, input icache_pkg::addr_t addr,
                             input icache_pkg::word_t data, input int aux);
        t_kind[n_entries] = kind;
        t_addr[n_entries] = addr;
        t_data[n_entries] = data;
        t_aux[n_entries]  = aux;
        n_entries++;
    endtask

    task automatic add_write(input icache_pkg::paddr_t addr, input icache_pkg::word_t data,
                             input int err);
        add_entry(K_WRITE, icache_pkg::addr_t'(addr), data, err);
    endtask

    task automatic add_read(input icache_pkg::paddr_t addr, input icache_pkg::word_t data,
                            input int err);
        add_entry(K_READ, icache_pkg::addr_t'(addr), data, err);
    endtask

    task automatic add_fetch(input icache_pkg::addr_t addr, input int reqs);
        add_entry(K_FETCH, addr, '0, reqs);
    endtask

    task automatic build_table();
        n_entries = 0;
        // cache disabled after reset
        add_fetch(16'h1000, 1);
        add_fetch(16'h1000, 1);
        add_fetch(16'h2344, 1);
        add_read(icache_pkg::REG_HITS, 0, 0);
        add_read(icache_pkg::REG_MISSES, 0, 0);
        // enabled cache misses then hits with low bits ignored
        add_write(icache_pkg::REG_CTRL, 32'h1, 0);
        add_read(icache_pkg::REG_CTRL, 32'h1, 0);
        add_fetch(16'h1000, 1);
        add_fetch(16'h1000, 0);
        add_fetch(16'h1002, 0);
        add_fetch(16'h0104, 1);
        add_fetch(16'h0104, 0);
        add_read(icache_pkg::REG_HITS, 3, 0);
        add_read(icache_pkg::REG_MISSES, 2, 0);
        // 0x1000 and 0x2000 share index 0
        add_fetch(16'h2000, 1);
        add_fetch(16'h1000, 1);
        add_fetch(16'h2000, 1);
        add_fetch(16'h0104, 0);
        add_read(icache_pkg::REG_HITS, 4, 0);
        add_read(icache_pkg::REG_MISSES, 5, 0);
        // flush with enable kept on
        add_write(icache_pkg::REG_CTRL, 32'h3, 0);
        add_read(icache_pkg::REG_CTRL, 32'h1, 0);
        add_fetch(16'h2000, 1);
        add_fetch(16'h0104, 1);
        add_fetch(16'h0104, 0);
        add_read(icache_pkg::REG_HITS, 5, 0);
        add_read(icache_pkg::REG_MISSES, 7, 0);
        // counter clear and bad offset
        add_write(icache_pkg::REG_HITS, 32'h1234, 0);
        add_write(icache_pkg::REG_MISSES, 32'hffff, 0);
        add_read(icache_pkg::REG_HITS, 0, 0);
        add_read(icache_pkg::REG_MISSES, 0, 0);
        add_read(4'hc, 0, 1);
        add_write(4'hc, 32'h1, 1);
        add_read(icache_pkg::REG_CTRL, 32'h1, 0);
        // mixed traffic then bypass again
        add_fetch(16'h3ffc, 1);
        add_fetch(16'h3ffc, 0);
        add_fetch(16'hfff8, 1);
        add_fetch(16'h0040, 1);
        add_fetch(16'h2000, 1);
        add_fetch(16'h0104, 0);
        add_read(icache_pkg::REG_HITS, 2, 0);
        add_read(icache_pkg::REG_MISSES, 4, 0);
        add_write(icache_pkg::REG_CTRL, 32'h0, 0);
        add_fetch(16'h0104, 1);
        add_fetch(16'hfff8, 1);
        add_read(icache_pkg::REG_HITS, 2, 0);
        add_read(icache_pkg::REG_MISSES, 4, 0);
    endtask

    // one apb transfer starting just after a rising edge
    task automatic apb_access(input logic write, input icache_pkg::paddr_t addr,
                              input icache_pkg::word_t wdata,
                              output icache_pkg::word_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_flag("pready", pready, 1'b1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic fetch(input icache_pkg::addr_t addr, output icache_pkg::word_t data);
        logic done;
        done          = 1'b0;
        cpu_req_addr  = addr;
        cpu_req_valid = 1'b1;
        while (!done)
        begin
            @(negedge clk);
            if (cpu_req_ready)
            begin
                done = 1'b1;
                data = cpu_req_data;
            end
        end
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
    endtask

    function automatic string kind_name(input int kind);
        case (kind)
            K_WRITE: return "apb write";
            K_READ:  return "apb read";
            default: return "fetch";
        endcase
    endfunction

    task automatic run_entry(input int idx);
        icache_pkg::word_t  rdata;
        icache_pkg::word_t  exp_data;
        icache_pkg::paddr_t reg_addr;
        logic               err;
        int                 reqs_before;
        int                 gap;
        entry_errors = 0;
        reg_addr     = icache_pkg::paddr_t'(t_addr[idx]);
        case (t_kind[idx])
            K_WRITE:
            begin
                apb_access(1'b1, reg_addr, t_data[idx], rdata, err);
                check_flag("pslverr", err, t_aux[idx] != 0);
            end
            K_READ:
            begin
                apb_access(1'b0, reg_addr, '0, rdata, err);
                check_flag("pslverr", err, t_aux[idx] != 0);
                if ((reg_addr == icache_pkg::REG_HITS) || (reg_addr == icache_pkg::REG_MISSES))
                begin
                    check_count("prdata", icache_pkg::count_t'(rdata),
                                icache_pkg::count_t'(t_data[idx]));
                end
                else
                begin
                    check_word("prdata", rdata, t_data[idx]);
                end
            end
            default:
            begin
                exp_data    = mem_words[t_addr[idx][icache_pkg::ADDR_W-1:2]];
                reqs_before = mem_reqs;
                fetch(t_addr[idx], rdata);
                check_word("cpu_req_data", rdata, exp_data);
                check_count("memory requests", icache_pkg::count_t'(mem_reqs - reqs_before),
                            icache_pkg::count_t'(t_aux[idx]));
                // idle gap before the next entry
                gap = int'({$random(seed)} % 4);
                repeat (gap)
                begin
                    @(posedge clk);
                    #1;
                end
            end
        endcase
        if (entry_errors == 0)
        begin
            pass_count++;
            $display("test %0d %s addr %h: ok", idx, kind_name(t_kind[idx]), t_addr[idx]);
        end
        else
        begin
            fail_count++;
            $display("test %0d %s addr %h: mismatch", idx, kind_name(t_kind[idx]), t_addr[idx]);
        end
    endtask

    initial
    begin
        int i;
        seed          = 40928;
        rst           = 1'b1;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        for (i = 0; i < MEM_WORDS; i++)
        begin
            mem_words[i] = $random(seed);
        end
        build_table();
        cycle_limit = n_entries * CYCLES_PER_ENTRY + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (i = 0; i < n_entries; i++)
        begin
            run_entry(i);
        end
        if (u_icache_top.u_core.u_chk.assert_failures != 0)
        begin
            $display("assertion checks failed %0d times",
                     u_icache_top.u_core.u_chk.assert_failures);
        end
        $display("passed %0d failed %0d", pass_count, fail_count);
        if ((fail_count == 0) && (u_icache_top.u_core.u_chk.assert_failures == 0))
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: icache.f
source/icache_pkg.sv
source/icache_array.sv
source/icache_core.sv
source/icache_regs.sv
source/icache_top.sv
dv/icache_chk.sv
dv/icache_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module icache_tb -f icache.f -o icache_sim || exit 1
out=$(./obj_dir/icache_sim)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }

// File: source/icache_array.sv
`timescale 1ns/1ns

module icache_array (
    input  logic                  clk,
    input  logic                  rst,
    input  icache_pkg::index_t    rd_index,
    output logic                  rd_valid,
    output icache_pkg::tag_t      rd_tag,
    output icache_pkg::word_t     rd_data,
    input  logic                  fill_en,
    input  icache_pkg::index_t    fill_index,
    input  icache_pkg::tag_t      fill_tag,
    input  icache_pkg::word_t     fill_data,
    input  logic                  inval_all
);

    icache_pkg::tag_t  tag_mem  [icache_pkg::LINES];
    icache_pkg::word_t data_mem [icache_pkg::LINES];
    logic [icache_pkg::LINES-1:0] valid_bits;

    // line storage, written only on refill
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_data;
        end
    end

    // synchronous read port
    always_ff @(posedge clk)
    begin
        rd_tag  <= tag_mem[rd_index];
        rd_data <= data_mem[rd_index];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_bits <= '0;
            rd_valid   <= 1'b0;
        end
        else
        begin
            rd_valid <= valid_bits[rd_index];
            // flush wins over a fill in the same cycle
            if (inval_all)
            begin
                valid_bits <= '0;
            end
            else if (fill_en)
            begin
                valid_bits[fill_index] <= 1'b1;
            end
        end
    end

endmodule

// File: source/icache_core.sv
`timescale 1ns/1ns

module icache_core (
    input  logic                  clk,
    input  logic                  rst,
    input  icache_pkg::addr_t     cpu_req_addr,
    input  logic                  cpu_req_valid,
    output icache_pkg::word_t     cpu_req_data,
    output logic                  cpu_req_ready,
    output icache_pkg::addr_t     mem_req_addr,
    output logic                  mem_req_valid,
    input  icache_pkg::word_t     mem_rdata,
    input  logic                  mem_req_ready,
    input  logic                  cache_enable,
    input  logic                  flush_req,
    output logic                  hit_event,
    output logic                  miss_event,
    output icache_pkg::index_t    rd_index,
    input  logic                  rd_valid,
    input  icache_pkg::tag_t      rd_tag,
    input  icache_pkg::word_t     rd_data,
    output logic                  fill_en,
    output icache_pkg::index_t    fill_index,
    output icache_pkg::tag_t      fill_tag,
    output icache_pkg::word_t     fill_data,
    output logic                  inval_all
);

    icache_pkg::cache_state_t state;
    icache_pkg::cache_state_t state_next;

    icache_pkg::addr_t req_addr;
    icache_pkg::tag_t  req_tag;
    icache_pkg::word_t resp_data;
    logic              bypass;
    logic              flush_pending;
    logic              go_flush;
    logic              accept;
    logic              hit;

    // field positions inside the byte address
    localparam int TAG_LSB   = icache_pkg::ADDR_W - icache_pkg::TAG_W;
    localparam int INDEX_LSB = TAG_LSB - icache_pkg::INDEX_W;

    assign req_tag  = req_addr[icache_pkg::ADDR_W-1:TAG_LSB];
    assign rd_index = cpu_req_addr[TAG_LSB-1:INDEX_LSB];

    assign go_flush = flush_pending || flush_req;
    assign accept   = (state == icache_pkg::IDLE) && cpu_req_valid && !go_flush;
    assign hit      = rd_valid && (rd_tag == req_tag);

    always_comb
    begin
        state_next = state;
        case (state)
            icache_pkg::IDLE:
            begin
                if (go_flush)
                begin
                    state_next = icache_pkg::FLUSH;
                end
                else if (cpu_req_valid)
                begin
                    // disabled cache goes straight to memory
                    state_next = cache_enable ? icache_pkg::LOOKUP : icache_pkg::REFILL;
                end
            end
            icache_pkg::LOOKUP:
            begin
                state_next = hit ? icache_pkg::IDLE : icache_pkg::REFILL;
            end
            icache_pkg::REFILL:
            begin
                if (mem_req_ready)
                begin
                    state_next = icache_pkg::RESPOND;
                end
            end
            icache_pkg::RESPOND:
            begin
                state_next = icache_pkg::IDLE;
            end
            icache_pkg::FLUSH:
            begin
                state_next = icache_pkg::IDLE;
            end
            default:
            begin
                state_next = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= icache_pkg::IDLE;
            flush_pending <= 1'b0;
            bypass        <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // a new flush request keeps the flag set for another pass
            if (flush_req)
            begin
                flush_pending <= 1'b1;
            end
            else if (state == icache_pkg::FLUSH)
            begin
                flush_pending <= 1'b0;
            end
            if (accept)
            begin
                bypass <= !cache_enable;
            end
        end
    end

    // request address and returned word
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_addr <= cpu_req_addr;
        end
        if ((state == icache_pkg::REFILL) && mem_req_ready)
        begin
            resp_data <= mem_rdata;
        end
    end

    assign mem_req_valid = (state == icache_pkg::REFILL);
    assign mem_req_addr  = {req_addr[icache_pkg::ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};

    // fetches accepted in bypass never fill
    assign fill_en    = (state == icache_pkg::REFILL) && mem_req_ready && !bypass;
    assign fill_index = req_addr[TAG_LSB-1:INDEX_LSB];
    assign fill_tag   = req_tag;
    assign fill_data  = mem_rdata;

    assign inval_all = (state == icache_pkg::FLUSH);

    assign cpu_req_ready = ((state == icache_pkg::LOOKUP) && hit) ||
                           (state == icache_pkg::RESPOND);
    assign cpu_req_data  = (state == icache_pkg::LOOKUP) ? rd_data : resp_data;

    assign hit_event  = (state == icache_pkg::LOOKUP) && hit;
    assign miss_event = (state == icache_pkg::RESPOND) && !bypass;

endmodule

// File: source/icache_pkg.sv
package icache_pkg;

    // fetch address split into tag, index and byte offset
    localparam int ADDR_W  = 16;
    localparam int WORD_W  = 32;
    localparam int INDEX_W = 4;
    localparam int LINES   = 16;
    localparam int TAG_W   = 10;

    // event counter width
    localparam int CNT_W   = 16;

    // apb register space
    localparam int PADDR_W = 4;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [CNT_W-1:0]   count_t;
    typedef logic [PADDR_W-1:0] paddr_t;

    // ctrl bit 0 enable, bit 1 flush (write one, reads zero)
    localparam paddr_t REG_CTRL   = 4'h0;
    localparam paddr_t REG_HITS   = 4'h4;
    localparam paddr_t REG_MISSES = 4'h8;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND,
        FLUSH
    } cache_state_t;

endpackage

// File: source/icache_regs.sv
`timescale 1ns/1ns

module icache_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  icache_pkg::paddr_t    paddr,
    input  icache_pkg::word_t     pwdata,
    output icache_pkg::word_t     prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  cache_enable,
    output logic                  flush_req,
    input  logic                  hit_event,
    input  logic                  miss_event
);

    icache_pkg::count_t hit_count;
    icache_pkg::count_t miss_count;
    logic               access;
    logic               wr_en;
    logic               addr_ok;

    assign access  = psel && penable;
    assign wr_en   = access && pwrite;
    assign addr_ok = (paddr == icache_pkg::REG_CTRL) ||
                     (paddr == icache_pkg::REG_HITS) ||
                     (paddr == icache_pkg::REG_MISSES);

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cache_enable <= 1'b0;
            flush_req    <= 1'b0;
        end
        else
        begin
            flush_req <= 1'b0;
            if (wr_en && (paddr == icache_pkg::REG_CTRL))
            begin
                cache_enable <= pwdata[0];
                flush_req    <= pwdata[1];
            end
        end
    end

    // counters saturate and any write clears them
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_count  <= '0;
            miss_count <= '0;
        end
        else
        begin
            if (wr_en && (paddr == icache_pkg::REG_HITS))
            begin
                hit_count <= '0;
            end
            else if (hit_event && (hit_count != '1))
            begin
                hit_count <= hit_count + 1'b1;
            end
            if (wr_en && (paddr == icache_pkg::REG_MISSES))
            begin
                miss_count <= '0;
            end
            else if (miss_event && (miss_count != '1))
            begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    always_comb
    begin
        prdata = '0;
        case (paddr)
            icache_pkg::REG_CTRL:   prdata = icache_pkg::word_t'(cache_enable);
            icache_pkg::REG_HITS:   prdata = icache_pkg::word_t'(hit_count);
            icache_pkg::REG_MISSES: prdata = icache_pkg::word_t'(miss_count);
            default:                prdata = '0;
        endcase
    end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ns

module icache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  icache_pkg::addr_t     cpu_req_addr,
    input  logic                  cpu_req_valid,
    output icache_pkg::word_t     cpu_req_data,
    output logic                  cpu_req_ready,
    output icache_pkg::addr_t     mem_req_addr,
    output logic                  mem_req_valid,
    input  icache_pkg::word_t     mem_rdata,
    input  logic                  mem_req_ready,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  icache_pkg::paddr_t    paddr,
    input  icache_pkg::word_t     pwdata,
    output icache_pkg::word_t     prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic               cache_enable;
    logic               flush_req;
    logic               hit_event;
    logic               miss_event;
    icache_pkg::index_t rd_index;
    logic               rd_valid;
    icache_pkg::tag_t   rd_tag;
    icache_pkg::word_t  rd_data;
    logic               fill_en;
    icache_pkg::index_t fill_index;
    icache_pkg::tag_t   fill_tag;
    icache_pkg::word_t  fill_data;
    logic               inval_all;

    icache_core u_core (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_rdata     (mem_rdata),
        .mem_req_ready (mem_req_ready),
        .cache_enable  (cache_enable),
        .flush_req     (flush_req),
        .hit_event     (hit_event),
        .miss_event    (miss_event),
        .rd_index      (rd_index),
        .rd_valid      (rd_valid),
        .rd_tag        (rd_tag),
        .rd_data       (rd_data),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_tag      (fill_tag),
        .fill_data     (fill_data),
        .inval_all     (inval_all)
    );

    icache_array u_array (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (rd_index),
        .rd_valid   (rd_valid),
        .rd_tag     (rd_tag),
        .rd_data    (rd_data),
        .fill_en    (fill_en),
        .fill_index (fill_index),
        .fill_tag   (fill_tag),
        .fill_data  (fill_data),
        .inval_all  (inval_all)
    );

    icache_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .cache_enable (cache_enable),
        .flush_req    (flush_req),
        .hit_event    (hit_event),
        .miss_event   (miss_event)
    );

endmodule
